//--- siggen_top.f
+incdir+test
rtl/siggen_pkg.sv
rtl/siggen_regs.sv
rtl/sine_lut.sv
rtl/sine_tone.sv
rtl/packet_framer.sv
rtl/siggen_top.sv
test/tb_siggen.sv

//--- test/siggen_model.svh
////////////////////////////////////////////////////////////
// Reference model for the signal generator testbench,
// included inside the testbench module.
////////////////////////////////////////////////////////////

`ifndef SIGGEN_MODEL_SVH
`define SIGGEN_MODEL_SVH

// Full-wave sine table, one entry per lookup step
int sine_tab [1 << LUT_ADDR_W];

// Round to nearest, halves away from zero
function automatic int round_real(real x);
  if (x >= 0.0) begin
    return $rtoi(x + 0.5);
  end
  return -$rtoi(0.5 - x);
endfunction

task automatic build_sine_table();
  real ang;
  for (int k = 0; k < (1 << LUT_ADDR_W); k++) begin
    ang = 2.0 * 3.14159265358979 * k / 256.0;
    sine_tab[k] = round_real(LUT_PEAK * $sin(ang));
  end
endtask

// Sample n of a tone: I is the scaled cosine, Q the scaled sine
function automatic logic [31:0] tone_word(int n, logic [31:0] freq, logic [15:0] amp);
  logic [31:0] ph;
  int          idx;
  int          i_val;
  int          q_val;
  ph    = n * freq;
  idx   = ph[PHASE_W-1 -: LUT_ADDR_W];
  i_val = ($signed(amp) * sine_tab[(idx + 64) % 256]) >>> 15;
  q_val = ($signed(amp) * sine_tab[idx]) >>> 15;
  return {i_val[15:0], q_val[15:0]};
endfunction

// Both components within one LSB
function automatic bit iq_close(logic [31:0] exp_w, logic [31:0] act_w);
  logic [15:0] di;
  logic [15:0] dq;
  di = act_w[31:16] - exp_w[31:16];
  dq = act_w[15:0] - exp_w[15:0];
  return (di == 16'd0 || di == 16'd1 || di == 16'hffff) &&
         (dq == 16'd0 || dq == 16'd1 || dq == 16'hffff);
endfunction

`endif

//--- test/tb_siggen.sv
////////////////////////////////////////////////////////////
// Testbench for the signal generator: random register and
// back-pressure stimulus, every output word model-checked.
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module tb_siggen import siggen_pkg::*; ();

  logic        ce_clk;
  logic        i_rst;
  logic        i_set_stb;
  logic [7:0]  i_set_addr;
  logic [31:0] i_set_data;
  logic        i_tready;
  logic [31:0] o_tdata;
  logic        o_tlast;
  logic        o_tvalid;

  integer seed;
  int     ready_pct;
  int     errors;
  int     err_start;
  int     tests_run;
  int     tests_failed;
  string  test_name;

  // Shadow of the user registers
  logic [31:0] sh_freq;
  logic [31:0] sh_cart;
  logic [15:0] sh_amp;
  logic        sh_run;
  logic        sh_const;
  logic [15:0] sh_size;
  logic [15:0] sh_sid;

  // Framing and phase state of the model
  logic        in_payload;
  int          pay_pos;
  int          size_lat;
  logic [15:0] seq_exp;
  logic [15:0] last_hdr_seq;
  int          hdr_count;
  int          sample_n;
  int          pkt_lens [$];

  `include "siggen_model.svh"

  siggen_top UUT (
    .ce_clk     (ce_clk),
    .i_rst      (i_rst),
    .i_set_stb  (i_set_stb),
    .i_set_addr (i_set_addr),
    .i_set_data (i_set_data),
    .i_tready   (i_tready),
    .o_tdata    (o_tdata),
    .o_tlast    (o_tlast),
    .o_tvalid   (o_tvalid)
  );

  always #2 ce_clk = ~ce_clk;

  always @(negedge ce_clk) begin
    i_tready <= ($unsigned($random(seed)) % 100) < ready_pct;
  end

  task automatic report_error(string what, logic [31:0] exp_v, logic [31:0] act_v);
    $display("[ERROR] %s: %s expected 0x%h actual 0x%h", test_name, what, exp_v, act_v);
    errors++;
  endtask

  ////////////////////////////////////////////////////////////
  // Output monitor and register shadow
  ////////////////////////////////////////////////////////////

  task automatic check_word();
    logic [31:0] exp_w;
    logic        exp_last;
    if (!in_payload) begin
      exp_w = {seq_exp, sh_sid};
      if (o_tdata !== exp_w) report_error("header word", exp_w, o_tdata);
      if (o_tlast !== 1'b0) report_error("header tlast", 0, o_tlast);
      last_hdr_seq = o_tdata[31:16];
      hdr_count++;
      seq_exp++;
      size_lat   = (sh_size == 16'd0) ? 1 : sh_size;
      pay_pos    = 0;
      in_payload = 1'b1;
    end else begin
      exp_last = (pay_pos == size_lat - 1);
      if (sh_const) begin
        if (o_tdata !== sh_cart) report_error("constant sample", sh_cart, o_tdata);
      end else begin
        exp_w = tone_word(sample_n, sh_freq, sh_amp);
        if (!iq_close(exp_w, o_tdata)) report_error("tone sample", exp_w, o_tdata);
      end
      if (o_tlast !== exp_last) report_error("payload tlast", exp_last, o_tlast);
      if (o_tlast === 1'b1) pkt_lens.push_back(pay_pos + 1);
      sample_n++;
      pay_pos++;
      if (exp_last) in_payload = 1'b0;
    end
  endtask

  task automatic shadow_write(logic [7:0] addr, logic [31:0] data);
    case (addr)
      SR_FREQ:      sh_freq = data;
      SR_CARTESIAN: sh_cart = data;
      SR_AMPLITUDE: sh_amp  = data[15:0];
      SR_ENABLE: begin
        // Fresh run restarts at phase 0
        if (data[0] && !sh_run) sample_n = 0;
        sh_run   = data[0];
        sh_const = data[1];
      end
      SR_PKT_SIZE:  sh_size = (data[15:0] == 16'd0) ? 16'd1 : data[15:0];
      SR_DST_SID:   sh_sid  = data[15:0];
      default: ;
    endcase
  endtask

  always @(posedge ce_clk) begin
    if (!i_rst && o_tvalid && i_tready) check_word();
    if (!i_rst && i_set_stb) shadow_write(i_set_addr, i_set_data);
  end

  ////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////

  task automatic write_reg(logic [7:0] addr, logic [31:0] data);
    @(negedge ce_clk);
    i_set_stb  = 1'b1;
    i_set_addr = addr;
    i_set_data = data;
    @(negedge ce_clk);
    i_set_stb  = 1'b0;
  endtask

  task automatic wait_samples(int count);
    int target;
    int cyc;
    target = sample_n + count;
    cyc    = 0;
    while (sample_n < target && cyc < 5000) begin
      @(negedge ce_clk);
      cyc++;
    end
    if (sample_n < target) begin
      $display("TIMEOUT in %s: fewer than %0d samples arrived", test_name, count);
      errors++;
    end
  endtask

  // Target is the total number of packets seen since reset
  task automatic wait_packets(int target);
    int cyc;
    cyc = 0;
    while (pkt_lens.size() < target && cyc < 5000) begin
      @(negedge ce_clk);
      cyc++;
    end
    if (pkt_lens.size() < target) begin
      $display("TIMEOUT in %s: packet count stuck at %0d", test_name, pkt_lens.size());
      errors++;
    end
  endtask

  task automatic wait_mid_packet();
    int cyc;
    cyc = 0;
    while (!(in_payload && pay_pos == 1) && cyc < 2000) begin
      @(negedge ce_clk);
      cyc++;
    end
    if (!(in_payload && pay_pos == 1)) begin
      $display("TIMEOUT in %s: never reached the middle of a packet", test_name);
      errors++;
    end
  endtask

  // Full ready until the output has been quiet for 8 cycles
  task automatic drain();
    int quiet;
    int cyc;
    int saved;
    saved     = ready_pct;
    ready_pct = 100;
    quiet     = 0;
    cyc       = 0;
    while (quiet < 8 && cyc < 1000) begin
      @(posedge ce_clk);
      quiet = o_tvalid ? 0 : quiet + 1;
      cyc++;
    end
    ready_pct = saved;
    if (quiet < 8) begin
      $display("TIMEOUT in %s: output did not drain after run was cleared", test_name);
      errors++;
    end
  endtask

  // Keep the mode bit so samples in flight stay in their mode
  task automatic stop_run();
    write_reg(SR_ENABLE, {30'd0, sh_const, 1'b0});
    drain();
  endtask

  task automatic start_test(string name);
    test_name = name;
    err_start = errors;
  endtask

  task automatic end_test();
    int n;
    n = errors - err_start;
    tests_run++;
    if (n > 0) tests_failed++;
    $display("Test %-12s %s (%0d errors)", test_name, (n == 0) ? "PASS" : "FAIL", n);
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int          done;
    int          old_size;
    logic [15:0] new_size;
    seed       = 32'h2743_02fa;
    ce_clk     = 1'b0;
    i_rst      = 1'b1;
    i_set_stb  = 1'b0;
    i_set_addr = '0;
    i_set_data = '0;
    i_tready   = 1'b0;
    ready_pct  = 70;
    errors     = 0;
    tests_run  = 0;
    tests_failed = 0;
    {sh_freq, sh_cart, sh_amp, sh_run, sh_const, sh_size, sh_sid} = '0;
    in_payload = 1'b0;
    pay_pos    = 0;
    size_lat   = 1;
    seq_exp    = '0;
    hdr_count  = 0;
    sample_n   = 0;
    build_sine_table();
    repeat (4) @(negedge ce_clk);
    i_rst = 1'b0;

    start_test("reset_idle");
    repeat (50) begin
      @(posedge ce_clk);
      if (o_tvalid !== 1'b0) report_error("idle o_tvalid", 0, o_tvalid);
    end
    end_test();

    start_test("const_mode");
    write_reg(SR_DST_SID, $random(seed));
    write_reg(SR_PKT_SIZE, 4 + ($unsigned($random(seed)) % 6));
    write_reg(SR_CARTESIAN, $random(seed));
    write_reg(SR_ENABLE, 32'd3);
    wait_packets(pkt_lens.size() + 3);
    stop_run();
    end_test();

    start_test("tone_values");
    write_reg(SR_FREQ, $random(seed));
    write_reg(SR_AMPLITUDE, $random(seed));
    write_reg(SR_ENABLE, 32'd1);
    wait_samples(64);
    stop_run();
    end_test();

    start_test("backpressure");
    ready_pct = 30;
    write_reg(SR_ENABLE, 32'd1);
    wait_samples(64);
    ready_pct = 70;
    end_test();

    // Tone keeps running from the previous test
    start_test("size_change");
    wait_mid_packet();
    old_size = size_lat;
    done     = pkt_lens.size();
    new_size = old_size + 3;
    write_reg(SR_PKT_SIZE, new_size);
    wait_packets(done + 2);
    if (pkt_lens.size() >= done + 2) begin
      if (pkt_lens[done] != old_size) report_error("current length", old_size, pkt_lens[done]);
      if (pkt_lens[done + 1] != new_size) begin
        report_error("next length", new_size, pkt_lens[done + 1]);
      end
    end
    end_test();

    start_test("re_enable");
    stop_run();
    write_reg(SR_ENABLE, 32'd1);
    wait_samples(32);
    // Sequence counts every header since reset
    if (last_hdr_seq !== 16'(hdr_count - 1)) begin
      report_error("sequence number", 16'(hdr_count - 1), last_hdr_seq);
    end
    end_test();

    $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

//--- rtl/siggen_top.sv
////////////////////////////////////////////////////////////
// Signal generator top level: register decoder, tone source
// and packet framer on a single clock.
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module siggen_top import siggen_pkg::*; (
  input  logic                ce_clk,
  input  logic                i_rst,
  input  logic                i_set_stb,
  input  logic [7:0]          i_set_addr,
  input  logic [31:0]         i_set_data,
  input  logic                i_tready,
  output logic [SAMPLE_W-1:0] o_tdata,
  output logic                o_tlast,
  output logic                o_tvalid
);

  logic [PHASE_W-1:0]  freq;
  logic [SAMPLE_W-1:0] cartesian;
  logic [IQ_W-1:0]     amplitude;
  logic                run;
  logic                const_mode;
  logic [15:0]         pkt_size;
  logic [15:0]         dst_sid;

  // Tone stream into the framer
  logic [SAMPLE_W-1:0] tone_tdata;
  logic                tone_tvalid;
  logic                tone_tready;

  siggen_regs u_regs (
    .ce_clk       (ce_clk),
    .i_rst        (i_rst),
    .i_set_stb    (i_set_stb),
    .i_set_addr   (i_set_addr),
    .i_set_data   (i_set_data),
    .o_freq       (freq),
    .o_cartesian  (cartesian),
    .o_amplitude  (amplitude),
    .o_run        (run),
    .o_const_mode (const_mode),
    .o_pkt_size   (pkt_size),
    .o_dst_sid    (dst_sid)
  );

  sine_tone u_tone (
    .ce_clk       (ce_clk),
    .i_rst        (i_rst),
    .i_freq       (freq),
    .i_cartesian  (cartesian),
    .i_amplitude  (amplitude),
    .i_run        (run),
    .i_const_mode (const_mode),
    .i_tready     (tone_tready),
    .o_tdata      (tone_tdata),
    .o_tvalid     (tone_tvalid)
  );

  packet_framer u_framer (
    .ce_clk      (ce_clk),
    .i_rst       (i_rst),
    .i_pkt_size  (pkt_size),
    .i_dst_sid   (dst_sid),
    .i_tdata     (tone_tdata),
    .i_tvalid    (tone_tvalid),
    .i_tready    (i_tready),
    .o_in_tready (tone_tready),
    .o_tdata     (o_tdata),
    .o_tlast     (o_tlast),
    .o_tvalid    (o_tvalid)
  );

endmodule

//--- rtl/packet_framer.sv
////////////////////////////////////////////////////////////
// Wraps the sample stream into packets: one header word with
// sequence number and destination ID, then the payload.
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module packet_framer import siggen_pkg::*; (
  input  logic                ce_clk,
  input  logic                i_rst,
  input  logic [15:0]         i_pkt_size,
  input  logic [15:0]         i_dst_sid,
  input  logic [SAMPLE_W-1:0] i_tdata,
  input  logic                i_tvalid,
  input  logic                i_tready,
  output logic                o_in_tready,
  output logic [SAMPLE_W-1:0] o_tdata,
  output logic                o_tlast,
  output logic                o_tvalid
);

  framer_state_e state;

  logic [15:0] seq_num;
  logic [15:0] size_q;
  logic [15:0] pay_cnt;
  logic        last_sample;
  logic        xfer;

  assign last_sample = (pay_cnt == size_q - 16'd1);
  assign xfer        = o_tvalid && i_tready;

  ////////////////////////////////////////////////////////////
  // Output mux
  ////////////////////////////////////////////////////////////

  // Header only goes out once a sample is waiting behind it
  always_comb begin
    o_tvalid = i_tvalid;
    if (state == FR_HEADER) begin
      o_tdata     = {seq_num, i_dst_sid};
      o_tlast     = 1'b0;
      o_in_tready = 1'b0;
    end else begin
      o_tdata     = i_tdata;
      o_tlast     = last_sample;
      o_in_tready = i_tready;
    end
  end

  ////////////////////////////////////////////////////////////
  // Packet FSM and counters
  ////////////////////////////////////////////////////////////

  always_ff @(posedge ce_clk) begin
    if (i_rst) begin
      state   <= FR_HEADER;
      seq_num <= '0;
      size_q  <= 16'd1;
      pay_cnt <= '0;
    end else if (xfer) begin
      case (state)
        FR_HEADER: begin
          // Size holds for the whole packet
          size_q  <= (i_pkt_size == 16'd0) ? 16'd1 : i_pkt_size;
          seq_num <= seq_num + 16'd1;
          pay_cnt <= '0;
          state   <= FR_PAYLOAD;
        end
        FR_PAYLOAD: begin
          pay_cnt <= pay_cnt + 16'd1;
          if (last_sample) begin
            state <= FR_HEADER;
          end
        end
        default: state <= FR_HEADER;
      endcase
    end
  end

  // Payload count stays below the latched packet size
  a_pay_in_range: assert property (@(posedge ce_clk) disable iff (i_rst)
    (state == FR_PAYLOAD) |-> (pay_cnt < size_q));

endmodule

//--- rtl/sine_tone.sv
////////////////////////////////////////////////////////////
// Complex tone source: accumulate, lookup, scale. The three
// stages move together and stall as one under back-pressure.
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module sine_tone import siggen_pkg::*; (
  input  logic                ce_clk,
  input  logic                i_rst,
  input  logic [PHASE_W-1:0]  i_freq,
  input  logic [SAMPLE_W-1:0] i_cartesian,
  input  logic [IQ_W-1:0]     i_amplitude,
  input  logic                i_run,
  input  logic                i_const_mode,
  input  logic                i_tready,
  output logic [SAMPLE_W-1:0] o_tdata,
  output logic                o_tvalid
);

  logic               advance;
  logic [PHASE_W-1:0] phase_acc;

  // Stage 1 and 2 payload and valid bits
  logic                  v1;
  logic                  v2;
  logic                  cm1;
  logic                  cm2;
  logic [LUT_ADDR_W-1:0] ph1;

  logic signed [IQ_W-1:0]     lut_sin;
  logic signed [IQ_W-1:0]     lut_cos;
  logic signed [2*IQ_W-1:0]   prod_i;
  logic signed [2*IQ_W-1:0]   prod_q;

  // Whole pipeline moves when the output slot is free or taken
  assign advance = !o_tvalid || i_tready;

  ////////////////////////////////////////////////////////////
  // Stage 1: phase accumulator
  ////////////////////////////////////////////////////////////

  always_ff @(posedge ce_clk) begin
    if (i_rst) begin
      phase_acc <= '0;
      v1        <= 1'b0;
    end else begin
      if (!i_run) begin
        phase_acc <= '0;
      end else if (advance) begin
        phase_acc <= phase_acc + i_freq;
      end
      if (advance) begin
        v1 <= i_run;
      end
    end
  end

  // Only the top phase bits reach the table
  always_ff @(posedge ce_clk) begin
    if (advance) begin
      ph1 <= phase_acc[PHASE_W-1 -: LUT_ADDR_W];
      cm1 <= i_const_mode;
    end
  end

  ////////////////////////////////////////////////////////////
  // Stage 2: table lookup
  ////////////////////////////////////////////////////////////

  sine_lut u_lut (
    .ce_clk  (ce_clk),
    .i_rst   (i_rst),
    .i_en    (advance),
    .i_phase (ph1),
    .o_sin   (lut_sin),
    .o_cos   (lut_cos)
  );

  always_ff @(posedge ce_clk) begin
    if (i_rst) begin
      v2 <= 1'b0;
    end else if (advance) begin
      v2 <= v1;
    end
  end

  always_ff @(posedge ce_clk) begin
    if (advance) begin
      cm2 <= cm1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Stage 3: amplitude scaling or constant word
  ////////////////////////////////////////////////////////////

  assign prod_i = $signed(i_amplitude) * lut_cos;
  assign prod_q = $signed(i_amplitude) * lut_sin;

  always_ff @(posedge ce_clk) begin
    if (i_rst) begin
      o_tvalid <= 1'b0;
    end else if (advance) begin
      o_tvalid <= v2;
    end
  end

  // Shift right by 15 and keep the low 16 bits
  always_ff @(posedge ce_clk) begin
    if (advance) begin
      o_tdata <= cm2 ? i_cartesian
                     : {prod_i[2*IQ_W-2 -: IQ_W], prod_q[2*IQ_W-2 -: IQ_W]};
    end
  end

  a_hold_on_stall: assert property (@(posedge ce_clk) disable iff (i_rst)
    (o_tvalid && !i_tready) |=> (o_tvalid && $stable(o_tdata)));

endmodule

//--- rtl/sine_lut.sv
////////////////////////////////////////////////////////////
// Sine and cosine lookup from a quarter-wave table.
// One cycle of latency, outputs advance only when i_en is high.
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module sine_lut import siggen_pkg::*; (
  input  logic                         ce_clk,
  input  logic                         i_rst,
  input  logic                         i_en,
  input  logic        [LUT_ADDR_W-1:0] i_phase,
  output logic signed [IQ_W-1:0]       o_sin,
  output logic signed [IQ_W-1:0]       o_cos
);

  // Entry k of the full wave is LUT_PEAK * sin(2*pi*k/256), rounded
  function automatic logic [IQ_W-1:0] qtr_entry(int k);
    real ang;
    ang = 2.0 * 3.14159265358979 * k / real'(1 << LUT_ADDR_W);
    return IQ_W'($rtoi(LUT_PEAK * $sin(ang) + 0.5));
  endfunction

  logic [IQ_W-1:0] qtr [LUT_QTR_N];

  for (genvar k = 0; k < LUT_QTR_N; k++) begin : g_qtr
    assign qtr[k] = qtr_entry(k);
  end

  ////////////////////////////////////////////////////////////
  // Quadrant folding
  ////////////////////////////////////////////////////////////

  // Bit 6 mirrors the index, bit 7 flips the sign
  function automatic logic signed [IQ_W-1:0] fold(logic [LUT_ADDR_W-1:0] ph);
    logic [LUT_ADDR_W-3:0] idx;
    logic [LUT_ADDR_W-2:0] addr;
    logic [IQ_W-1:0]       mag;
    idx  = ph[LUT_ADDR_W-3:0];
    addr = ph[LUT_ADDR_W-2] ? (LUT_ADDR_W-1)'(LUT_QTR_N - 1) - idx : {1'b0, idx};
    mag  = qtr[addr];
    return ph[LUT_ADDR_W-1] ? -mag : mag;
  endfunction

  // Cosine is sine a quarter turn ahead
  logic [LUT_ADDR_W-1:0] phase_cos;

  assign phase_cos = i_phase + LUT_ADDR_W'(1 << (LUT_ADDR_W - 2));

  always_ff @(posedge ce_clk) begin
    if (i_rst) begin
      o_sin <= '0;
      o_cos <= '0;
    end else if (i_en) begin
      o_sin <= fold(i_phase);
      o_cos <= fold(phase_cos);
    end
  end

  a_sin_range: assert property (@(posedge ce_clk) disable iff (i_rst)
    (o_sin <= LUT_PEAK) && (o_sin >= -LUT_PEAK));

endmodule

//--- rtl/siggen_regs.sv
////////////////////////////////////////////////////////////
// User register file written by the host over the settings
// bus. Values show on the outputs one cycle after the strobe.
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module siggen_regs import siggen_pkg::*; (
  input  logic                ce_clk,
  input  logic                i_rst,
  input  logic                i_set_stb,
  input  logic [7:0]          i_set_addr,
  input  logic [31:0]         i_set_data,
  output logic [PHASE_W-1:0]  o_freq,
  output logic [SAMPLE_W-1:0] o_cartesian,
  output logic [IQ_W-1:0]     o_amplitude,
  output logic                o_run,
  output logic                o_const_mode,
  output logic [15:0]         o_pkt_size,
  output logic [15:0]         o_dst_sid
);

  always_ff @(posedge ce_clk) begin
    if (i_rst) begin
      o_freq       <= '0;
      o_cartesian  <= '0;
      o_amplitude  <= '0;
      o_run        <= 1'b0;
      o_const_mode <= 1'b0;
      o_pkt_size   <= '0;
      o_dst_sid    <= '0;
    end else if (i_set_stb) begin
      // Unknown addresses fall through untouched
      case (siggen_reg_e'(i_set_addr))
        SR_FREQ:      o_freq      <= i_set_data[PHASE_W-1:0];
        SR_CARTESIAN: o_cartesian <= i_set_data[SAMPLE_W-1:0];
        SR_AMPLITUDE: o_amplitude <= i_set_data[IQ_W-1:0];
        SR_ENABLE: begin
          o_run        <= i_set_data[0];
          o_const_mode <= i_set_data[1];
        end
        // A zero-length packet would never end, so store one
        SR_PKT_SIZE:  o_pkt_size  <= (i_set_data[15:0] == 16'd0) ? 16'd1 : i_set_data[15:0];
        SR_DST_SID:   o_dst_sid   <= i_set_data[15:0];
        default: ;
      endcase
    end
  end

  // Register outputs only move right after a host write
  a_change_after_stb: assert property (@(posedge ce_clk) disable iff (i_rst)
    !$past(i_set_stb) |-> $stable({o_freq, o_cartesian, o_amplitude, o_run,
                                   o_const_mode, o_pkt_size, o_dst_sid}));

endmodule

//--- rtl/siggen_pkg.sv
////////////////////////////////////////////////////////////
// Shared register map, widths and state types for the
// signal generator. Modules pull these in by wildcard import.
////////////////////////////////////////////////////////////

package siggen_pkg;

  ////////////////////////////////////////////////////////////
  // User register map
  ////////////////////////////////////////////////////////////

  // Addresses below 128 belong to the shell and are not decoded here
  typedef enum logic [7:0] {
    SR_FREQ      = 8'd128,  // Phase increment per sample
    SR_CARTESIAN = 8'd130,  // Constant I/Q word
    SR_ENABLE    = 8'd132,  // Bit 0 run, bit 1 constant mode
    SR_AMPLITUDE = 8'd138,  // Signed scale factor
    SR_PKT_SIZE  = 8'd140,  // Samples per packet
    SR_DST_SID   = 8'd141   // Destination stream ID
  } siggen_reg_e;

  ////////////////////////////////////////////////////////////
  // Data path widths
  ////////////////////////////////////////////////////////////

  // Stream word, I in the upper half and Q in the lower half
  localparam int SAMPLE_W = 32;
  localparam int IQ_W     = 16;

  // Phase accumulator and the top bits used for table lookup
  localparam int PHASE_W    = 32;
  localparam int LUT_ADDR_W = 8;

  // Quarter wave plus the end point at 90 degrees
  localparam int LUT_QTR_N = (1 << (LUT_ADDR_W - 2)) + 1;

  // Full-scale table value
  localparam int LUT_PEAK = 32767;

  ////////////////////////////////////////////////////////////
  // Framer FSM
  ////////////////////////////////////////////////////////////

  typedef enum logic {
    FR_HEADER,
    FR_PAYLOAD
  } framer_state_e;

endpackage
